// ==== logic/axi_pkg.sv ====
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;   // Beats minus one.
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Shared by AR and AW.
    typedef struct packed {
        axi_addr_t  addr;
        axi_id_t    id;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
        axi_id_t   id;
    } axi_r_t;

    typedef struct packed {
        axi_resp_t resp;
        axi_id_t   id;
    } axi_b_t;

endpackage

// ==== logic/soc_pkg.sv ====
package soc_pkg;

    typedef logic [15:0] clint_ofs_t;
    typedef logic [63:0] mtime_t;

    // Upper address half of the core-local region.
    localparam logic [15:0] CLINT_BASE = 16'h0200;

    localparam clint_ofs_t MTIME_LO_OFS = 16'hbff8;
    localparam clint_ofs_t MTIME_HI_OFS = 16'hbffc;

    typedef enum logic [1:0] {
        GNT_IDLE = 2'd0,
        GNT_IFU  = 2'd1,
        GNT_LSU  = 2'd2
    } grant_e;

endpackage

// ==== logic/bus_grant_fsm.sv ====
`timescale 1ns/1ps

module bus_grant_fsm
    import axi_pkg::*, soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ifu_req,
    input  logic      lsu_rd_req,
    input  logic      lsu_wr_req,
    input  axi_addr_t lsu_araddr,
    input  logic      xact_done,
    output grant_e    gnt,
    output logic      clint_sel
);

    grant_e gnt_next;
    logic   lsu_grant;
    logic   in_clint;

    always_comb begin
        gnt_next = gnt;
        case (gnt)
            GNT_IDLE: begin
                if (lsu_rd_req || lsu_wr_req) begin
                    gnt_next = GNT_LSU; // Lsu has priority.
                end else if (ifu_req) begin
                    gnt_next = GNT_IFU;
                end
            end
            GNT_IFU, GNT_LSU: begin
                if (xact_done) begin
                    gnt_next = GNT_IDLE;
                end
            end
            default: gnt_next = GNT_IDLE;
        endcase
    end

    assign lsu_grant = (gnt == GNT_IDLE) && (gnt_next == GNT_LSU);
    assign in_clint  = (lsu_araddr[31:16] == CLINT_BASE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt       <= GNT_IDLE;
            clint_sel <= 1'b0;
        end else begin
            gnt <= gnt_next;
            // Target fixed for the whole transaction.
            if (lsu_grant) begin
                clint_sel <= lsu_rd_req && in_clint;
            end
        end
    end

endmodule

// ==== logic/bus_route_mux.sv ====
`timescale 1ns/1ps

module bus_route_mux
    import axi_pkg::*, soc_pkg::*;
(
    input  grant_e  gnt,
    input  logic    clint_sel,

    input  logic    ifu_ar_valid,
    output logic    ifu_ar_ready,
    input  axi_ax_t ifu_ar,
    output logic    ifu_r_valid,
    input  logic    ifu_r_ready,
    output axi_r_t  ifu_r,

    input  logic    lsu_ar_valid,
    output logic    lsu_ar_ready,
    input  axi_ax_t lsu_ar,
    output logic    lsu_r_valid,
    input  logic    lsu_r_ready,
    output axi_r_t  lsu_r,
    input  logic    lsu_aw_valid,
    output logic    lsu_aw_ready,
    input  axi_ax_t lsu_aw,
    input  logic    lsu_w_valid,
    output logic    lsu_w_ready,
    input  axi_w_t  lsu_w,
    output logic    lsu_b_valid,
    input  logic    lsu_b_ready,
    output axi_b_t  lsu_b,

    output logic    mem_ar_valid,
    input  logic    mem_ar_ready,
    output axi_ax_t mem_ar,
    input  logic    mem_r_valid,
    output logic    mem_r_ready,
    input  axi_r_t  mem_r,
    output logic    mem_aw_valid,
    input  logic    mem_aw_ready,
    output axi_ax_t mem_aw,
    output logic    mem_w_valid,
    input  logic    mem_w_ready,
    output axi_w_t  mem_w,
    input  logic    mem_b_valid,
    output logic    mem_b_ready,
    input  axi_b_t  mem_b,

    output logic    clint_ar_valid,
    input  logic    clint_ar_ready,
    output axi_ax_t clint_ar,
    input  logic    clint_r_valid,
    output logic    clint_r_ready,
    input  axi_r_t  clint_r,

    output logic    xact_done
);

    always_comb begin
        ifu_ar_ready   = 1'b0;
        ifu_r_valid    = 1'b0;
        ifu_r          = '0;
        lsu_ar_ready   = 1'b0;
        lsu_r_valid    = 1'b0;
        lsu_r          = '0;
        lsu_aw_ready   = 1'b0;
        lsu_w_ready    = 1'b0;
        lsu_b_valid    = 1'b0;
        lsu_b          = '0;
        mem_ar_valid   = 1'b0;
        mem_ar         = '0;
        mem_r_ready    = 1'b0;
        mem_aw_valid   = 1'b0;
        mem_aw         = '0;
        mem_w_valid    = 1'b0;
        mem_w          = '0;
        mem_b_ready    = 1'b0;
        clint_ar_valid = 1'b0;
        clint_ar       = '0;
        clint_r_ready  = 1'b0;
        xact_done      = 1'b0;

        case (gnt)
            GNT_IFU: begin
                mem_ar_valid = ifu_ar_valid;
                mem_ar       = ifu_ar;
                ifu_ar_ready = mem_ar_ready;
                ifu_r_valid  = mem_r_valid;
                ifu_r        = mem_r;
                mem_r_ready  = ifu_r_ready;
                xact_done    = mem_r_valid && ifu_r_ready && mem_r.last;
            end
            GNT_LSU: begin
                if (clint_sel) begin
                    clint_ar_valid = lsu_ar_valid;
                    clint_ar       = lsu_ar;
                    lsu_ar_ready   = clint_ar_ready;
                    lsu_r_valid    = clint_r_valid;
                    lsu_r          = clint_r;
                    clint_r_ready  = lsu_r_ready;
                    xact_done      = clint_r_valid && lsu_r_ready && clint_r.last;
                end else begin
                    mem_ar_valid = lsu_ar_valid;
                    mem_ar       = lsu_ar;
                    lsu_ar_ready = mem_ar_ready;
                    lsu_r_valid  = mem_r_valid;
                    lsu_r        = mem_r;
                    mem_r_ready  = lsu_r_ready;
                    mem_aw_valid = lsu_aw_valid;
                    mem_aw       = lsu_aw;
                    lsu_aw_ready = mem_aw_ready;
                    mem_w_valid  = lsu_w_valid;
                    mem_w        = lsu_w;
                    lsu_w_ready  = mem_w_ready;
                    lsu_b_valid  = mem_b_valid;
                    lsu_b        = mem_b;
                    mem_b_ready  = lsu_b_ready;
                    // Last read beat or write response.
                    xact_done = (mem_r_valid && lsu_r_ready && mem_r.last) ||
                                (mem_b_valid && lsu_b_ready);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer
    import axi_pkg::*, soc_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ax_t ar,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r
);

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc_cnt;
    logic          tick;
    mtime_t        mtime;
    clint_ofs_t    ofs;
    axi_data_t     rd_data;
    axi_resp_t     rd_resp;
    logic          ar_hs;

    assign tick = (presc_cnt == PW'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc_cnt <= '0;
            mtime     <= '0;
        end else if (tick) begin
            presc_cnt <= '0;
            mtime     <= mtime + 64'd1;
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // One response at a time.
    assign ar_ready = !r_valid;
    assign ar_hs    = ar_valid && ar_ready;
    assign ofs      = ar.addr[15:0];

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (ofs)
            MTIME_LO_OFS: rd_data = mtime[31:0];
            MTIME_HI_OFS: rd_data = mtime[63:32];
            default:      rd_resp = RESP_SLVERR; // Unmapped offset.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (ar_hs) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r.data <= rd_data;
            r.resp <= rd_resp;
            r.last <= 1'b1;  // Single beat only.
            r.id   <= ar.id;
        end
    end

endmodule

// ==== logic/mem_xbar_top.sv ====
`timescale 1ns/1ps

module mem_xbar_top
    import axi_pkg::*, soc_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    ifu_ar_valid,
    output logic    ifu_ar_ready,
    input  axi_ax_t ifu_ar,
    output logic    ifu_r_valid,
    input  logic    ifu_r_ready,
    output axi_r_t  ifu_r,

    input  logic    lsu_ar_valid,
    output logic    lsu_ar_ready,
    input  axi_ax_t lsu_ar,
    output logic    lsu_r_valid,
    input  logic    lsu_r_ready,
    output axi_r_t  lsu_r,
    input  logic    lsu_aw_valid,
    output logic    lsu_aw_ready,
    input  axi_ax_t lsu_aw,
    input  logic    lsu_w_valid,
    output logic    lsu_w_ready,
    input  axi_w_t  lsu_w,
    output logic    lsu_b_valid,
    input  logic    lsu_b_ready,
    output axi_b_t  lsu_b,

    output logic    io_master_ar_valid,
    input  logic    io_master_ar_ready,
    output axi_ax_t io_master_ar,
    input  logic    io_master_r_valid,
    output logic    io_master_r_ready,
    input  axi_r_t  io_master_r,
    output logic    io_master_aw_valid,
    input  logic    io_master_aw_ready,
    output axi_ax_t io_master_aw,
    output logic    io_master_w_valid,
    input  logic    io_master_w_ready,
    output axi_w_t  io_master_w,
    input  logic    io_master_b_valid,
    output logic    io_master_b_ready,
    input  axi_b_t  io_master_b
);

    grant_e  gnt;
    logic    clint_sel;
    logic    xact_done;
    logic    clint_ar_valid;
    logic    clint_ar_ready;
    axi_ax_t clint_ar;
    logic    clint_r_valid;
    logic    clint_r_ready;
    axi_r_t  clint_r;

    bus_grant_fsm u_grant (
        .clk        (clk),
        .rst        (rst),
        .ifu_req    (ifu_ar_valid),
        .lsu_rd_req (lsu_ar_valid),
        .lsu_wr_req (lsu_aw_valid),
        .lsu_araddr (lsu_ar.addr),
        .xact_done  (xact_done),
        .gnt        (gnt),
        .clint_sel  (clint_sel)
    );

    bus_route_mux u_route (
        .gnt            (gnt),
        .clint_sel      (clint_sel),
        .ifu_ar_valid   (ifu_ar_valid),
        .ifu_ar_ready   (ifu_ar_ready),
        .ifu_ar         (ifu_ar),
        .ifu_r_valid    (ifu_r_valid),
        .ifu_r_ready    (ifu_r_ready),
        .ifu_r          (ifu_r),
        .lsu_ar_valid   (lsu_ar_valid),
        .lsu_ar_ready   (lsu_ar_ready),
        .lsu_ar         (lsu_ar),
        .lsu_r_valid    (lsu_r_valid),
        .lsu_r_ready    (lsu_r_ready),
        .lsu_r          (lsu_r),
        .lsu_aw_valid   (lsu_aw_valid),
        .lsu_aw_ready   (lsu_aw_ready),
        .lsu_aw         (lsu_aw),
        .lsu_w_valid    (lsu_w_valid),
        .lsu_w_ready    (lsu_w_ready),
        .lsu_w          (lsu_w),
        .lsu_b_valid    (lsu_b_valid),
        .lsu_b_ready    (lsu_b_ready),
        .lsu_b          (lsu_b),
        .mem_ar_valid   (io_master_ar_valid),
        .mem_ar_ready   (io_master_ar_ready),
        .mem_ar         (io_master_ar),
        .mem_r_valid    (io_master_r_valid),
        .mem_r_ready    (io_master_r_ready),
        .mem_r          (io_master_r),
        .mem_aw_valid   (io_master_aw_valid),
        .mem_aw_ready   (io_master_aw_ready),
        .mem_aw         (io_master_aw),
        .mem_w_valid    (io_master_w_valid),
        .mem_w_ready    (io_master_w_ready),
        .mem_w          (io_master_w),
        .mem_b_valid    (io_master_b_valid),
        .mem_b_ready    (io_master_b_ready),
        .mem_b          (io_master_b),
        .clint_ar_valid (clint_ar_valid),
        .clint_ar_ready (clint_ar_ready),
        .clint_ar       (clint_ar),
        .clint_r_valid  (clint_r_valid),
        .clint_r_ready  (clint_r_ready),
        .clint_r        (clint_r),
        .xact_done      (xact_done)
    );

    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_clint (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (clint_ar_valid),
        .ar_ready (clint_ar_ready),
        .ar       (clint_ar),
        .r_valid  (clint_r_valid),
        .r_ready  (clint_r_ready),
        .r        (clint_r)
    );

endmodule

// ==== tests/mem_xbar_checker.sv ====
`timescale 1ns/1ps

module mem_xbar_checker
    import axi_pkg::*, soc_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input grant_e  gnt,
    input logic    clint_ar_valid,
    input logic    io_ar_valid,
    input logic    io_ar_ready,
    input axi_ax_t io_ar,
    input logic    io_aw_valid,
    input logic    io_aw_ready,
    input axi_ax_t io_aw,
    input logic    ifu_r_valid
);

    // Only one slave sees a read address.
    ar_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(io_ar_valid && clint_ar_valid))
        else $error("io_master and timer AR valid in the same cycle");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        io_ar_valid && !io_ar_ready |=> io_ar_valid && $stable(io_ar))
        else $error("io_master AR dropped or changed before ready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        io_aw_valid && !io_aw_ready |=> io_aw_valid && $stable(io_aw))
        else $error("io_master AW dropped or changed before ready");

    ifu_r_blocked: assert property (@(posedge clk) disable iff (rst)
        gnt == GNT_LSU |-> !ifu_r_valid)
        else $error("ifu saw R valid while the lsu held the bus");

endmodule

bind mem_xbar_top mem_xbar_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .gnt            (gnt),
    .clint_ar_valid (clint_ar_valid),
    .io_ar_valid    (io_master_ar_valid),
    .io_ar_ready    (io_master_ar_ready),
    .io_ar          (io_master_ar),
    .io_aw_valid    (io_master_aw_valid),
    .io_aw_ready    (io_master_aw_ready),
    .io_aw          (io_master_aw),
    .ifu_r_valid    (ifu_r_valid)
);

// ==== tests/mem_xbar_tb.sv ====
`timescale 1ns/1ps

module mem_xbar_tb
    import axi_pkg::*, soc_pkg::*;
();

    localparam int TICK_DIV = 4;
    localparam int TIMEOUT  = 400;

    logic    clk;
    logic    rst;
    logic    ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
    axi_ax_t ifu_ar;
    axi_r_t  ifu_r;
    logic    lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
    logic    lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready, lsu_b_valid, lsu_b_ready;
    axi_ax_t lsu_ar, lsu_aw;
    axi_r_t  lsu_r;
    axi_w_t  lsu_w;
    axi_b_t  lsu_b;
    logic    io_master_ar_valid, io_master_ar_ready, io_master_r_valid, io_master_r_ready;
    logic    io_master_aw_valid, io_master_aw_ready, io_master_w_valid, io_master_w_ready;
    logic    io_master_b_valid, io_master_b_ready;
    axi_ax_t io_master_ar, io_master_aw;
    axi_r_t  io_master_r;
    axi_w_t  io_master_w;
    axi_b_t  io_master_b;

    axi_r_t      exp_r [16][$];  // Expected beats per id.
    axi_b_t      exp_b [16][$];
    axi_data_t   shadow [axi_addr_t];
    axi_data_t   mem_store [axi_addr_t];
    axi_id_t     ar_log [$];      // Order of ids seen on io_master AR.
    int          seed;
    bit          bp_on;
    bit          clint_busy;
    string       test_name;
    logic [11:0] idle_vec;

    assign idle_vec = {ifu_ar_ready, ifu_r_valid, lsu_ar_ready, lsu_r_valid, lsu_aw_ready,
                       lsu_w_ready, lsu_b_valid, io_master_ar_valid, io_master_r_ready,
                       io_master_aw_valid, io_master_w_valid, io_master_b_ready};

    mem_xbar_top #(
        .TICK_DIV (TICK_DIV)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic axi_data_t merge_strb(axi_data_t old, axi_data_t data, axi_strb_t strb);
        axi_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // Reference word for an address.
    function automatic axi_data_t expect_word(axi_addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic axi_data_t mem_word(axi_addr_t addr);
        if (mem_store.exists(addr)) return mem_store[addr];
        return addr ^ 32'h5a5a_0000;  // Unwritten words.
    endfunction

    function automatic logic ready_bit();
        logic [31:0] rnd;
        if (!bp_on) return 1'b1;
        rnd = $random(seed);
        return rnd[1:0] != 2'b00;
    endfunction

    task automatic rand_delay();
        logic [31:0] rnd;
        rnd = $random(seed);
        repeat (rnd[1:0] % 3) @(negedge clk);
    endtask

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic step_wait(inout int cnt, input string what);
        @(posedge clk);
        cnt++;
        if (cnt > TIMEOUT) report_fail($sformatf("Timed out waiting for %s", what));
    endtask

    task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            report_fail($sformatf("FAIL %s %s expected %0h actual %0h",
                                  test_name, what, exp, act));
        end
    endtask

    task automatic check_r_beat(input axi_r_t act);
        axi_r_t exp;
        assert (exp_r[act.id].size() != 0)
            else report_fail($sformatf("Read beat with id %0d had no request pending", act.id));
        exp = exp_r[act.id].pop_front();
        expect_eq("r beat", 64'(exp), 64'(act));
    endtask

    task automatic check_b(input axi_b_t act);
        axi_b_t exp;
        assert (exp_b[act.id].size() != 0)
            else report_fail($sformatf("Write response with id %0d had no write pending", act.id));
        exp = exp_b[act.id].pop_front();
        expect_eq("b response", 64'(exp), 64'(act));
    endtask

    task automatic ifu_read(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
        axi_r_t e;
        int     cnt;
        int     beats;
        for (int i = 0; i <= int'(len); i++) begin
            e = '{data: expect_word(addr + axi_addr_t'(4 * i)), resp: RESP_OKAY,
                  last: (i == int'(len)), id: id};
            exp_r[id].push_back(e);
        end
        ifu_ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        ifu_ar_valid = 1'b1;
        cnt = 0;
        do step_wait(cnt, "ifu AR handshake"); while (!ifu_ar_ready);
        @(negedge clk);
        ifu_ar_valid = 1'b0;
        beats = 0;
        cnt = 0;
        while (beats <= int'(len)) begin
            ifu_r_ready = ready_bit();
            step_wait(cnt, "ifu read beats");
            if (ifu_r_valid && ifu_r_ready) beats++;
            @(negedge clk);
        end
        ifu_r_ready = 1'b0;
    endtask

    task automatic lsu_read(input axi_addr_t addr, input axi_len_t len, input axi_id_t id,
                            output axi_r_t beat);
        axi_r_t e;
        bit     timer;
        int     cnt;
        int     beats;
        timer = (addr[31:16] == CLINT_BASE);
        clint_busy = timer;  // Timer data is checked by the caller.
        for (int i = 0; i <= int'(len) && !timer; i++) begin
            e = '{data: expect_word(addr + axi_addr_t'(4 * i)), resp: RESP_OKAY,
                  last: (i == int'(len)), id: id};
            exp_r[id].push_back(e);
        end
        lsu_ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        lsu_ar_valid = 1'b1;
        cnt = 0;
        do step_wait(cnt, "lsu AR handshake"); while (!lsu_ar_ready);
        @(negedge clk);
        lsu_ar_valid = 1'b0;
        beats = 0;
        cnt = 0;
        while (beats <= int'(len)) begin
            lsu_r_ready = ready_bit();
            step_wait(cnt, "lsu read beats");
            if (lsu_r_valid && lsu_r_ready) begin
                beat = lsu_r;
                beats++;
            end
            @(negedge clk);
        end
        lsu_r_ready = 1'b0;
        clint_busy = 1'b0;
    endtask

    task automatic lsu_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                             input axi_id_t id);
        axi_b_t e;
        bit     aw_done;
        bit     w_done;
        bit     b_done;
        int     cnt;
        e = '{resp: RESP_OKAY, id: id};
        exp_b[id].push_back(e);
        shadow[addr] = merge_strb(expect_word(addr), data, strb);
        lsu_aw = '{addr: addr, id: id, len: 8'd0, size: 3'd2, burst: 2'b01};
        lsu_w = '{data: data, strb: strb, last: 1'b1};
        lsu_aw_valid = 1'b1;
        lsu_w_valid = 1'b1;
        aw_done = 1'b0;
        w_done = 1'b0;
        cnt = 0;
        while (!(aw_done && w_done)) begin
            step_wait(cnt, "lsu AW and W handshakes");
            if (lsu_aw_valid && lsu_aw_ready) aw_done = 1'b1;
            if (lsu_w_valid && lsu_w_ready) w_done = 1'b1;
            @(negedge clk);
            if (aw_done) lsu_aw_valid = 1'b0;
            if (w_done) lsu_w_valid = 1'b0;
        end
        b_done = 1'b0;
        cnt = 0;
        while (!b_done) begin
            lsu_b_ready = ready_bit();
            step_wait(cnt, "lsu write response");
            if (lsu_b_valid && lsu_b_ready) b_done = 1'b1;
            @(negedge clk);
        end
        lsu_b_ready = 1'b0;
    endtask

    // Downstream memory with random ready delays.
    initial begin : io_slave
        axi_ax_t   req;
        axi_addr_t a;
        int        cnt;
        forever begin
            @(posedge clk);
            if (!rst && io_master_ar_valid) begin
                @(negedge clk);
                rand_delay();
                io_master_ar_ready = 1'b1;
                cnt = 0;
                do step_wait(cnt, "io_master AR valid"); while (!io_master_ar_valid);
                req = io_master_ar;
                ar_log.push_back(req.id);
                @(negedge clk);
                io_master_ar_ready = 1'b0;
                for (int i = 0; i <= int'(req.len); i++) begin
                    rand_delay();
                    io_master_r_valid = 1'b1;
                    io_master_r = '{data: mem_word(req.addr + axi_addr_t'(4 * i)),
                                    resp: RESP_OKAY, last: (i == int'(req.len)), id: req.id};
                    cnt = 0;
                    do step_wait(cnt, "io_master R ready"); while (!io_master_r_ready);
                    @(negedge clk);
                    io_master_r_valid = 1'b0;
                end
            end else if (!rst && io_master_aw_valid) begin
                @(negedge clk);
                rand_delay();
                io_master_aw_ready = 1'b1;
                cnt = 0;
                do step_wait(cnt, "io_master AW valid"); while (!io_master_aw_valid);
                req = io_master_aw;
                @(negedge clk);
                io_master_aw_ready = 1'b0;
                for (int i = 0; i <= int'(req.len); i++) begin
                    rand_delay();
                    io_master_w_ready = 1'b1;
                    cnt = 0;
                    do step_wait(cnt, "io_master W valid"); while (!io_master_w_valid);
                    a = req.addr + axi_addr_t'(4 * i);
                    mem_store[a] = merge_strb(mem_word(a), io_master_w.data, io_master_w.strb);
                    @(negedge clk);
                    io_master_w_ready = 1'b0;
                end
                rand_delay();
                io_master_b_valid = 1'b1;
                io_master_b = '{resp: RESP_OKAY, id: req.id};
                cnt = 0;
                do step_wait(cnt, "io_master B ready"); while (!io_master_b_ready);
                @(negedge clk);
                io_master_b_valid = 1'b0;
            end
        end
    end

    initial begin : compare_proc
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (ifu_r_valid && ifu_r_ready) check_r_beat(ifu_r);
                if (lsu_r_valid && lsu_r_ready && !clint_busy) check_r_beat(lsu_r);
                if (lsu_b_valid && lsu_b_ready) check_b(lsu_b);
                if (clint_busy) begin
                    assert (!io_master_ar_valid)
                        else report_fail("io_master AR was raised during a timer read");
                end
            end
        end
    end

    initial begin : main_seq
        axi_r_t      beat;
        axi_data_t   t0;
        axi_addr_t   addr;
        logic [31:0] rnd;
        seed = 32'h67b2_c9d1;
        bp_on = 1'b0;
        clint_busy = 1'b0;
        rst = 1'b1;
        {ifu_ar_valid, ifu_r_ready, lsu_ar_valid, lsu_r_ready} = '0;
        {lsu_aw_valid, lsu_w_valid, lsu_b_ready} = '0;
        {ifu_ar, lsu_ar, lsu_aw, lsu_w} = '0;
        {io_master_ar_ready, io_master_r_valid, io_master_aw_ready} = '0;
        {io_master_w_ready, io_master_b_valid} = '0;
        io_master_r = '0;
        io_master_b = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_name = "idle after reset";
        repeat (8) begin
            @(posedge clk);
            expect_eq("valid and ready outputs", 64'd0, 64'(idle_vec));
        end
        @(negedge clk);

        test_name = "ifu burst";
        ifu_read(32'h8000_0100, 8'd3, 4'd3);

        test_name = "lsu write strobe";
        lsu_write(32'h8000_0040, 32'hdead_beef, 4'b0101, 4'd9);
        lsu_read(32'h8000_0040, 8'd0, 4'd10, beat);

        test_name = "same edge priority";
        ar_log.delete();
        fork
            ifu_read(32'h8000_0200, 8'd1, 4'd5);
            lsu_read(32'h8000_0300, 8'd0, 4'd12, beat);
        join
        expect_eq("AR count", 64'd2, 64'(ar_log.size()));
        expect_eq("first AR id", 64'd12, 64'(ar_log[0]));
        expect_eq("second AR id", 64'd5, 64'(ar_log[1]));

        test_name = "timer reads";
        lsu_read({CLINT_BASE, MTIME_LO_OFS}, 8'd0, 4'd13, beat);
        t0 = beat.data;
        expect_eq("mtime resp", 64'(RESP_OKAY), 64'(beat.resp));
        expect_eq("mtime rid", 64'd13, 64'(beat.id));
        repeat (TICK_DIV + 2) @(negedge clk);
        lsu_read({CLINT_BASE, MTIME_LO_OFS}, 8'd0, 4'd14, beat);
        assert (beat.data > t0) else begin
            report_fail($sformatf("FAIL %s mtime expected above %0h actual %0h",
                                  test_name, t0, beat.data));
        end
        lsu_read({CLINT_BASE, 16'h0010}, 8'd0, 4'd15, beat);
        expect_eq("unmapped resp", 64'(RESP_SLVERR), 64'(beat.resp));
        expect_eq("unmapped data", 64'd0, 64'(beat.data));

        test_name = "random mixed";
        bp_on = 1'b1;
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            addr = {24'h8000_00, 2'b00, rnd[7:4], 2'b00};
            case (rnd[1:0])
                2'd0: ifu_read(addr, {6'd0, rnd[9:8]}, {1'b0, rnd[18:16]});
                2'd1: lsu_read(addr, 8'd0, {1'b1, rnd[22:20]}, beat);
                2'd2: lsu_write(addr, $random(seed), rnd[13:10], {1'b1, rnd[22:20]});
                default: begin
                    fork
                        ifu_read(addr, {6'd0, rnd[9:8]}, {1'b0, rnd[18:16]});
                        lsu_read(addr ^ 32'h40, 8'd0, {1'b1, rnd[22:20]}, beat);
                    join
                end
            endcase
        end

        for (int i = 0; i < 16; i++) begin
            assert (exp_r[i].size() == 0 && exp_b[i].size() == 0)
                else report_fail($sformatf("Responses for id %0d never arrived", i));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
logic/axi_pkg.sv
logic/soc_pkg.sv
logic/bus_grant_fsm.sv
logic/bus_route_mux.sv
logic/clint_timer.sv
logic/mem_xbar_top.sv
tests/mem_xbar_checker.sv
tests/mem_xbar_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module mem_xbar_tb -o mem_xbar_sim

# The log decides the result.
./obj_dir/mem_xbar_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
